//--- pet_bus_core.f
+incdir+.
pet_timing_pkg.sv
pet_bus_pkg.sv
pet_slot_timer.sv
pet_addr_decode.sv
pet_bus_drive.sv
pet_read_capture.sv
pet_bus_core.sv
tb_pet_bus_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the pet_bus_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_pet_bus_core -f pet_bus_core.f -o sim

out=$(./obj_dir/sim)
echo "$out"

if grep -qF -- "*** PASSED ***" <<< "$out"; then
    exit 0
fi
exit 1

//--- tb_pet_bus_core.sv
`timescale 1ns/1ps
`include "pet_settings.svh"

module tb_pet_bus_core;

    localparam int N_TESTS = 6;
    localparam int CLK_NS  = 4;

    logic                    clk16 = 1'b0;
    logic                    rst;
    logic                    spi_valid;
    pet_bus_pkg::spi_req_t   spi_req;
    logic                    spi_ready;
    logic [7:0]              spi_rd_data;
    logic [15:0]             bus_addr;
    logic                    bus_rw_n;
    logic [7:0]              bus_data;
    logic [13:0]             video_addr;
    logic                    gfx;
    pet_bus_pkg::bus_drive_t bus;
    pet_bus_pkg::mem_ctl_t   mem_ctl;
    logic                    cpu_clk;
    logic                    cpu_be;

    logic [7:0]  mem [0:131071];    // 128 KB memory model
    logic        poke_en;
    logic [16:0] poke_addr;
    logic [7:0]  poke_data;
    logic [3:0]  phase;             // Tracks the slot counter
    logic [31:0] rng = 32'd36;
    int          errors = 0;

    pet_bus_core i_pet_bus_core (
        .clk16_i       (clk16),
        .rst_i         (rst),
        .spi_valid_i   (spi_valid),
        .spi_req_i     (spi_req),
        .spi_ready_o   (spi_ready),
        .spi_rd_data_o (spi_rd_data),
        .bus_addr_i    (bus_addr),
        .bus_rw_ni     (bus_rw_n),
        .bus_data_i    (bus_data),
        .video_addr_i  (video_addr),
        .gfx_i         (gfx),
        .bus_o         (bus),
        .mem_o         (mem_ctl),
        .cpu_clk_o     (cpu_clk),
        .cpu_be_o      (cpu_be)
    );

    initial begin
        forever #(CLK_NS / 2) clk16 = ~clk16;
    end

    always @(posedge clk16) begin
        if (rst) begin
            phase <= 4'd0;
        end else begin
            phase <= phase + 4'd1;  // Wraps at 15
        end
    end

    assign bus_data = mem[bus.addr];   // Combinational read

    always @(posedge clk16) begin
        if (rst) begin
            for (int a = 0; a < 131072; a++) begin
                mem[a[16:0]] <= a[7:0] ^ a[15:8] ^ {7'h00, a[16]};
            end
        end else if (poke_en) begin
            mem[poke_addr] <= poke_data;
        end else if (mem_ctl.ram_we) begin
            mem[bus.addr] <= bus.data;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare_bus(input pet_bus_pkg::bus_drive_t got, input pet_bus_pkg::bus_drive_t exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %0t %s: bus_o got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_mem(input pet_bus_pkg::mem_ctl_t got, input pet_bus_pkg::mem_ctl_t exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %0t %s: mem_o got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_data(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %0t %s: got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Slot now visible on the pins, two cycles behind the counter
    function automatic pet_timing_pkg::slot_e out_slot();
        logic [3:0] c;
        c = phase - 4'd2;
        if (c <= `PET_SPI_LAST) begin
            return pet_timing_pkg::SLOT_SPI;
        end else if (c <= `PET_VIDEO_LAST) begin
            return pet_timing_pkg::SLOT_VIDEO;
        end
        return pet_timing_pkg::SLOT_CPU;
    endfunction

    // Expected pins with no SPI request pending
    function automatic pet_bus_pkg::bus_drive_t expect_bus(input pet_timing_pkg::slot_e s);
        pet_bus_pkg::bus_drive_t b;
        b      = '0;
        b.data = spi_req.wr_data;
        b.rw_n = 1'b1;
        if (s == pet_timing_pkg::SLOT_VIDEO) begin
            b.addr    = {`PET_VIDEO_PREFIX, video_addr};
            b.addr_oe = 1'b1;
        end else if (s == pet_timing_pkg::SLOT_CPU) begin
            b.addr = {1'b0, bus_addr};
        end
        return b;
    endfunction

    function automatic pet_bus_pkg::mem_ctl_t expect_mem(input pet_timing_pkg::slot_e s);
        pet_bus_pkg::mem_ctl_t m;
        logic                  io;
        m  = '0;
        io = (bus_addr[15:8] == `PET_IO_PAGE);
        if (s == pet_timing_pkg::SLOT_VIDEO) begin
            m.ram_oe      = 1'b1;
            m.ram_addr_hi = video_addr[11:10];
        end else if (s == pet_timing_pkg::SLOT_CPU) begin
            m.ram_oe      = bus_rw_n && ({1'b0, bus_addr} < `PET_RAM_TOP);
            m.ram_addr_hi = (bus_addr[15:11] == 5'b10000) ? 2'b00 : bus_addr[11:10];
            m.pia1_cs     = io && bus_addr[4];
            m.pia2_cs     = io && bus_addr[5];
            m.via_cs      = io && bus_addr[6];
            m.io_oe       = io;
        end
        return m;
    endfunction

    task automatic check_idle(input int cycles, input string what);
        pet_timing_pkg::slot_e s;
        repeat (cycles) begin
            @(negedge clk16);
            s = out_slot();
            compare_bus(bus, expect_bus(s), what);
            compare_mem(mem_ctl, expect_mem(s), what);
            compare_bit(cpu_clk, s == pet_timing_pkg::SLOT_CPU, {what, " cpu_clk_o"});
            compare_bit(cpu_be, s != pet_timing_pkg::SLOT_SPI, {what, " cpu_be_o"});
            compare_bit(spi_ready, 1'b0, {what, " spi_ready_o"});
        end
    endtask

    task automatic poke(input logic [16:0] a, input logic [7:0] d);
        poke_addr = a;
        poke_data = d;
        poke_en   = 1'b1;
        @(negedge clk16);
        poke_en = 1'b0;
    endtask

    // Holds valid until ready, then watches for stray pulses
    task automatic spi_transfer(input pet_bus_pkg::spi_req_t req, output logic [7:0] rd,
                                output int we_cnt);
        int                      wait_cnt;
        int                      ready_cnt;
        pet_bus_pkg::bus_drive_t exp;
        exp         = '0;
        exp.addr    = req.addr.flat;
        exp.addr_oe = 1'b1;
        exp.data    = req.wr_data;
        exp.data_oe = 1'b1;
        exp.rw_noe  = 1'b1;
        we_cnt      = 0;
        ready_cnt   = 0;
        wait_cnt    = 0;
        rd          = 8'h00;
        spi_req     = req;
        spi_valid   = 1'b1;
        while (ready_cnt == 0 && wait_cnt < 40) begin
            @(negedge clk16);
            wait_cnt++;
            if (mem_ctl.ram_we) begin
                we_cnt++;
                compare_bus(bus, exp, "spi write strobe");
            end
            if (spi_ready) begin
                ready_cnt++;
                rd = spi_rd_data;
            end
        end
        spi_valid = 1'b0;
        spi_req   = '0;
        if (ready_cnt == 0) begin
            errors++;
            $display("Error at %0t: spi_ready_o never came within 40 cycles", $time);
        end
        repeat (32) begin
            @(negedge clk16);
            ready_cnt += int'(spi_ready);
            we_cnt    += int'(mem_ctl.ram_we);
        end
        compare_data(8'(ready_cnt), 8'd1, "spi_ready_o pulses per request");
    endtask

    task automatic test_idle();
        repeat (16) @(negedge clk16);
        check_idle(16, "idle after reset");
    endtask

    task automatic test_spi_write();
        pet_bus_pkg::spi_req_t req;
        logic [7:0]            rd;
        int                    we_cnt;
        rng           = xorshift(rng);
        req.rw_n      = 1'b0;
        req.addr.flat = {2'b00, rng[14:0]};
        req.wr_data   = rng[23:16];
        spi_transfer(req, rd, we_cnt);
        compare_data(8'(we_cnt), 8'd1, "ram_we pulses for a write");
        compare_data(mem[req.addr.flat], req.wr_data, "memory after spi write");
    endtask

    task automatic test_spi_read();
        pet_bus_pkg::spi_req_t req;
        logic [7:0]            rd;
        int                    we_cnt;
        rng           = xorshift(rng);
        req           = '0;
        req.rw_n      = 1'b1;
        req.addr.flat = {2'b00, rng[14:0]};
        poke(req.addr.flat, rng[31:24]);
        spi_transfer(req, rd, we_cnt);
        compare_data(rd, rng[31:24], "spi read data");
        compare_data(8'(we_cnt), 8'd0, "ram_we pulses for a read");
    endtask

    task automatic test_gfx_read();
        pet_bus_pkg::spi_req_t req;
        logic [7:0]            rd;
        int                    we_cnt;
        for (int g = 0; g < 2; g++) begin
            gfx           = g[0];
            req           = '0;
            req.rw_n      = 1'b1;
            req.addr.flat = `PET_GFX_REG;
            spi_transfer(req, rd, we_cnt);
            compare_data(rd, {7'h00, g[0]}, "gfx status read");
        end
    endtask

    task automatic test_io_selects();
        for (int i = 0; i < 3; i++) begin
            bus_addr = 16'hE800 | (16'h0010 << i);   // PIA1, PIA2, VIA
            repeat (16) @(negedge clk16);
            check_idle(32, "cpu io select");
        end
    endtask

    task automatic test_mirror();
        rng      = xorshift(rng);
        bus_addr = 16'h8400 | {6'b0, rng[9:0]};     // Inside the 80 column window
        repeat (16) @(negedge clk16);
        check_idle(32, "mirrored cpu access");
        bus_addr = 16'h0C00 | {1'b0, rng[14:0]};
        repeat (16) @(negedge clk16);
        check_idle(32, "plain cpu access");
    endtask

    initial begin
        #(N_TESTS * 200 * CLK_NS);
        $display("Watchdog expired before the tests finished, %0d errors so far", errors);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        spi_valid  = 1'b0;
        spi_req    = '0;
        bus_addr   = 16'hC000;      // ROM, nothing enabled
        bus_rw_n   = 1'b1;
        gfx        = 1'b0;
        poke_en    = 1'b0;
        poke_addr  = '0;
        poke_data  = '0;
        rng        = xorshift(rng);
        video_addr = rng[13:0];
        repeat (8) @(negedge clk16);
        rst = 1'b0;

        test_idle();
        test_spi_write();
        test_spi_read();
        test_gfx_read();
        test_io_selects();
        test_mirror();

        $display("Tests done, %0d errors", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- pet_bus_core.sv
`timescale 1ns/1ps

module pet_bus_core (
    input  logic                    clk16_i,
    input  logic                    rst_i,
    input  logic                    spi_valid_i,
    input  pet_bus_pkg::spi_req_t   spi_req_i,
    output logic                    spi_ready_o,
    output logic [7:0]              spi_rd_data_o,
    input  logic [15:0]             bus_addr_i,
    input  logic                    bus_rw_ni,
    input  logic [7:0]              bus_data_i,
    input  logic [13:0]             video_addr_i,
    input  logic                    gfx_i,
    output pet_bus_pkg::bus_drive_t bus_o,
    output pet_bus_pkg::mem_ctl_t   mem_o,
    output logic                    cpu_clk_o,
    output logic                    cpu_be_o
);

    pet_timing_pkg::slot_t slot;
    pet_bus_pkg::cycle_t   cycle_dec;   // Decoder to bus drive
    pet_bus_pkg::cycle_t   cycle_cap;   // Bus drive to capture

    pet_slot_timer i_pet_slot_timer (
        .clk16_i   (clk16_i),
        .rst_i     (rst_i),
        .slot_o    (slot),
        .cpu_clk_o (cpu_clk_o),
        .cpu_be_o  (cpu_be_o)
    );

    pet_addr_decode i_pet_addr_decode (
        .clk16_i      (clk16_i),
        .rst_i        (rst_i),
        .slot_i       (slot),
        .spi_valid_i  (spi_valid_i),
        .spi_req_i    (spi_req_i),
        .bus_addr_i   (bus_addr_i),
        .bus_rw_ni    (bus_rw_ni),
        .video_addr_i (video_addr_i),
        .cycle_o      (cycle_dec)
    );

    pet_bus_drive i_pet_bus_drive (
        .clk16_i (clk16_i),
        .rst_i   (rst_i),
        .cycle_i (cycle_dec),
        .bus_o   (bus_o),
        .mem_o   (mem_o),
        .cycle_o (cycle_cap)
    );

    pet_read_capture i_pet_read_capture (
        .clk16_i       (clk16_i),
        .rst_i         (rst_i),
        .cycle_i       (cycle_cap),
        .bus_data_i    (bus_data_i),
        .gfx_i         (gfx_i),
        .spi_rd_data_o (spi_rd_data_o),
        .spi_ready_o   (spi_ready_o)
    );

endmodule

//--- pet_read_capture.sv
`timescale 1ns/1ps

module pet_read_capture (
    input  logic                clk16_i,
    input  logic                rst_i,
    input  pet_bus_pkg::cycle_t cycle_i,
    input  logic [7:0]          bus_data_i,
    input  logic                gfx_i,
    output logic [7:0]          spi_rd_data_o,
    output logic                spi_ready_o
);

    logic done;     // Last cycle of a served SPI slot

    assign done = cycle_i.slot.strobe && (cycle_i.spi_rd || cycle_i.spi_wr);

    // Read data holds until the next SPI read
    always_ff @(posedge clk16_i) begin
        if (cycle_i.slot.strobe && cycle_i.spi_rd) begin
            if (cycle_i.gfx) begin
                spi_rd_data_o <= {7'h00, gfx_i};   // Status bit, not memory
            end else begin
                spi_rd_data_o <= bus_data_i;
            end
        end
    end

    always_ff @(posedge clk16_i) begin
        if (rst_i) begin
            spi_ready_o <= 1'b0;
        end else begin
            spi_ready_o <= done;    // One pulse per request
        end
    end

endmodule

//--- pet_bus_drive.sv
`timescale 1ns/1ps

module pet_bus_drive (
    input  logic                    clk16_i,
    input  logic                    rst_i,
    input  pet_bus_pkg::cycle_t     cycle_i,
    output pet_bus_pkg::bus_drive_t bus_o,
    output pet_bus_pkg::mem_ctl_t   mem_o,
    output pet_bus_pkg::cycle_t     cycle_o
);

    logic spi_own;
    logic cpu_own;
    logic any_rd;
    logic any_wr;

    assign spi_own = cycle_i.spi_rd || cycle_i.spi_wr;
    assign cpu_own = cycle_i.cpu_rd || cycle_i.cpu_wr;
    assign any_rd  = cycle_i.spi_rd || cycle_i.cpu_rd;
    assign any_wr  = cycle_i.spi_wr || cycle_i.cpu_wr;

    always_ff @(posedge clk16_i) begin
        // Payload, no reset
        bus_o.addr <= cycle_i.addr.flat;
        bus_o.data <= cycle_i.wr_data;
        bus_o.rw_n <= !cycle_i.spi_wr;

        if (rst_i) begin
            bus_o.addr_oe <= 1'b0;
            bus_o.data_oe <= 1'b0;
            bus_o.rw_noe  <= 1'b0;
            mem_o         <= '0;
        end else begin
            bus_o.addr_oe <= spi_own || cycle_i.video;
            bus_o.data_oe <= cycle_i.spi_wr;
            bus_o.rw_noe  <= spi_own;

            mem_o.ram_oe <= (cycle_i.ram && any_rd) || cycle_i.video;
            mem_o.ram_we <= cycle_i.ram && any_wr && cycle_i.slot.strobe;

            // 80 col screen folds onto the first KB for the CPU only
            mem_o.ram_addr_hi <= (cycle_i.mirrored && cpu_own)
                ? 2'b00
                : cycle_i.addr.flat[11:10];

            mem_o.pia1_cs <= cycle_i.pia1 && cpu_own;
            mem_o.pia2_cs <= cycle_i.pia2 && cpu_own;
            mem_o.via_cs  <= cycle_i.via  && cpu_own;
            mem_o.io_oe   <= cycle_i.io   && cpu_own;
        end
    end

    // Delayed copy so capture sees the cycle that is on the bus
    always_ff @(posedge clk16_i) begin
        cycle_o <= cycle_i;
        if (rst_i) begin
            cycle_o.slot   <= '0;
            cycle_o.spi_rd <= 1'b0;
            cycle_o.spi_wr <= 1'b0;
            cycle_o.cpu_rd <= 1'b0;
            cycle_o.cpu_wr <= 1'b0;
            cycle_o.video  <= 1'b0;
        end
    end

endmodule

//--- pet_addr_decode.sv
`timescale 1ns/1ps
`include "pet_settings.svh"

module pet_addr_decode (
    input  logic                   clk16_i,
    input  logic                   rst_i,
    input  pet_timing_pkg::slot_t  slot_i,
    input  logic                   spi_valid_i,
    input  pet_bus_pkg::spi_req_t  spi_req_i,
    input  logic [15:0]            bus_addr_i,
    input  logic                   bus_rw_ni,
    input  logic [13:0]            video_addr_i,
    output pet_bus_pkg::cycle_t    cycle_o
);

    pet_bus_pkg::cycle_t cycle_d;
    logic                spi_take;      // Request accepted at start of SPI slot
    logic                spi_active;
    logic                in_spi;
    logic                in_video;
    logic                in_cpu;

    assign in_spi   = (slot_i.slot == pet_timing_pkg::SLOT_SPI);
    assign in_video = (slot_i.slot == pet_timing_pkg::SLOT_VIDEO);
    assign in_cpu   = (slot_i.slot == pet_timing_pkg::SLOT_CPU);

    // Decide once per slot so a late request never gets half a slot
    always_ff @(posedge clk16_i) begin
        if (rst_i) begin
            spi_take <= 1'b0;
        end else if (in_spi && slot_i.first) begin
            spi_take <= spi_valid_i;
        end
    end

    assign spi_active = in_spi && (slot_i.first ? spi_valid_i : spi_take);

    always_comb begin
        cycle_d         = '0;
        cycle_d.slot    = slot_i;
        cycle_d.wr_data = spi_req_i.wr_data;

        // Address source for this slot
        if (spi_active) begin
            cycle_d.addr = spi_req_i.addr;
        end else if (in_video) begin
            cycle_d.addr.flat = {`PET_VIDEO_PREFIX, video_addr_i};
        end else if (in_cpu) begin
            cycle_d.addr.flat = {1'b0, bus_addr_i};
        end

        cycle_d.spi_rd = spi_active &&  spi_req_i.rw_n;
        cycle_d.spi_wr = spi_active && !spi_req_i.rw_n;
        cycle_d.cpu_rd = in_cpu &&  bus_rw_ni;
        cycle_d.cpu_wr = in_cpu && !bus_rw_ni;
        cycle_d.video  = in_video;

        // Region decode
        cycle_d.ram      = (cycle_d.addr.flat < `PET_RAM_TOP);
        cycle_d.io       = !cycle_d.addr.io.bank && (cycle_d.addr.io.page == `PET_IO_PAGE);
        cycle_d.pia1     = cycle_d.io && cycle_d.addr.io.reg_no[4];
        cycle_d.pia2     = cycle_d.io && cycle_d.addr.io.reg_no[5];
        cycle_d.via      = cycle_d.io && cycle_d.addr.io.reg_no[6];
        cycle_d.gfx      = (cycle_d.addr.flat == `PET_GFX_REG);
        cycle_d.mirrored = !cycle_d.addr.io.bank
                        && (cycle_d.addr.io.page >= `PET_MIRROR_FIRST)
                        && (cycle_d.addr.io.page <= `PET_MIRROR_LAST);
    end

    always_ff @(posedge clk16_i) begin
        cycle_o <= cycle_d;
        if (rst_i) begin
            cycle_o.slot   <= '0;
            cycle_o.spi_rd <= 1'b0;
            cycle_o.spi_wr <= 1'b0;
            cycle_o.cpu_rd <= 1'b0;
            cycle_o.cpu_wr <= 1'b0;
            cycle_o.video  <= 1'b0;
        end
    end

endmodule

//--- pet_slot_timer.sv
`timescale 1ns/1ps
`include "pet_settings.svh"

module pet_slot_timer (
    input  logic                  clk16_i,
    input  logic                  rst_i,
    output pet_timing_pkg::slot_t slot_o,
    output logic                  cpu_clk_o,
    output logic                  cpu_be_o
);

    pet_timing_pkg::cnt_t cnt;
    pet_timing_pkg::cnt_t cnt_prev;     // Counter value seen at the bus outputs next cycle

    function automatic pet_timing_pkg::slot_e slot_of(input pet_timing_pkg::cnt_t c);
        pet_timing_pkg::slot_e s;
        if (c <= `PET_SPI_LAST) begin
            s = pet_timing_pkg::SLOT_SPI;
        end else if (c <= `PET_VIDEO_LAST) begin
            s = pet_timing_pkg::SLOT_VIDEO;
        end else begin
            s = pet_timing_pkg::SLOT_CPU;
        end
        return s;
    endfunction

    always_ff @(posedge clk16_i) begin
        if (rst_i) begin
            cnt <= '0;
        end else if (cnt == 4'(`PET_CPU_PERIOD - 1)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 4'd1;
        end
    end

    // Slot info straight from the counter register
    assign slot_o.slot   = slot_of(cnt);
    assign slot_o.first  = (cnt == 4'd0)
                        || (cnt == `PET_SPI_LAST + 4'd1)
                        || (cnt == `PET_VIDEO_LAST + 4'd1);
    assign slot_o.strobe = (cnt == `PET_SPI_LAST)
                        || (cnt == `PET_VIDEO_LAST)
                        || (cnt == 4'(`PET_CPU_PERIOD - 1));

    // Two pipeline stages sit between the counter and the bus pins, so the
    // CPU clock looks one count back to line up with the registered outputs
    assign cnt_prev = cnt - 4'd1;

    always_ff @(posedge clk16_i) begin
        if (rst_i) begin
            cpu_clk_o <= 1'b0;
            cpu_be_o  <= 1'b0;
        end else begin
            cpu_clk_o <= (slot_of(cnt_prev) == pet_timing_pkg::SLOT_CPU);
            cpu_be_o  <= (slot_of(cnt_prev) != pet_timing_pkg::SLOT_SPI);  // Bus given to MCU
        end
    end

endmodule

//--- pet_bus_pkg.sv
package pet_bus_pkg;

    // I/O view of a bus address
    typedef struct packed {
        logic       bank;
        logic [7:0] page;
        logic [7:0] reg_no;
    } io_addr_t;

    // One bus address, read flat or as bank/page/register
    typedef union packed {
        logic [16:0] flat;
        io_addr_t    io;
    } addr_u;

    // Parallel request from the MCU
    typedef struct packed {
        logic       rw_n;       // 1 = read
        addr_u      addr;
        logic [7:0] wr_data;
    } spi_req_t;

    // Decoded cycle passed down the pipeline
    typedef struct packed {
        pet_timing_pkg::slot_t slot;
        logic       spi_rd;
        logic       spi_wr;
        logic       cpu_rd;
        logic       cpu_wr;
        logic       video;
        logic       ram;
        logic       pia1;
        logic       pia2;
        logic       via;
        logic       io;
        logic       gfx;
        logic       mirrored;
        addr_u      addr;
        logic [7:0] wr_data;
    } cycle_t;

    // External bus drivers
    typedef struct packed {
        logic [16:0] addr;
        logic        addr_oe;
        logic [7:0]  data;
        logic        data_oe;
        logic        rw_n;
        logic        rw_noe;
    } bus_drive_t;

    // RAM and chip select controls
    typedef struct packed {
        logic       ram_oe;
        logic       ram_we;
        logic [1:0] ram_addr_hi;    // RAM A11:A10
        logic       pia1_cs;
        logic       pia2_cs;
        logic       via_cs;
        logic       io_oe;
    } mem_ctl_t;

endpackage

//--- pet_timing_pkg.sv
package pet_timing_pkg;

    // Position inside one CPU period
    typedef logic [3:0] cnt_t;

    // Who owns the shared bus in the current cycle
    typedef enum logic [1:0] {
        SLOT_SPI   = 2'd0,
        SLOT_VIDEO = 2'd1,
        SLOT_CPU   = 2'd2
    } slot_e;

    // Output of the slot sequencer
    typedef struct packed {
        slot_e slot;
        logic  strobe;  // Last cycle of the slot
        logic  first;   // First cycle of the slot
    } slot_t;

endpackage

//--- pet_settings.svh
`ifndef PET_SETTINGS_SVH
`define PET_SETTINGS_SVH

// clk16_i cycles per CPU cycle
`define PET_CPU_PERIOD 16

// Last counter value of each slot; CPU slot runs to PET_CPU_PERIOD - 1
`define PET_SPI_LAST   4'd3
`define PET_VIDEO_LAST 4'd7

// Memory map
`define PET_RAM_TOP    17'h08000   // First address above main RAM
`define PET_IO_PAGE    8'hE8       // PIA1, PIA2, VIA and CRTC live here
`define PET_GFX_REG    17'h0E80F   // Graphics status register

// 80 column screen window, folded onto the first 1 KB of video RAM
`define PET_MIRROR_FIRST 8'h80
`define PET_MIRROR_LAST  8'h87

// Prefix for video fetches in the upper bank
`define PET_VIDEO_PREFIX 3'b010

`endif
